// File: Makefile
# Verilator flow for the gyro loop testbench

TOP := fog_loop_tb

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f fog_loop.f --top-module $(TOP)

# pass only when the testbench prints its pass line
run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps -Ihdl hdl/fog_loop_pkg.sv \
		hdl/fog_mod_gen.sv hdl/fog_err_demod.sv hdl/fog_step_gen.sv \
		hdl/fog_ramp_gen.sv hdl/fog_loop_top.sv --top-module fog_loop_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: bench/fog_loop_tb.sv
module fog_loop_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import fog_loop_pkg::*;

	localparam int MAX_TESTS = 16;

	// data file columns after the test name
	localparam int C_HALF   = 0;
	localparam int C_AMP_H  = 1;
	localparam int C_AMP_L  = 2;
	localparam int C_WAIT   = 3;
	localparam int C_POL    = 4;
	localparam int C_OFFS   = 5;
	localparam int C_FB     = 6;
	localparam int C_GSTEP  = 7;
	localparam int C_CONST  = 8;
	localparam int C_GRAMP  = 9;
	localparam int C_ADC_H  = 10;
	localparam int C_ADC_L  = 11;
	localparam int C_FOLLOW = 12;
	localparam int C_JIT    = 13;
	localparam int C_UPD    = 14;
	localparam int C_ERR    = 15;
	localparam int C_STEP   = 16;
	localparam int N_COLS   = 17;

	logic        CLOCK_DAC_1 = 1'b0;
	logic        i_rst_n = 1'b0;
	adc_sample_t i_adc = '0;
	cnt_word_t   i_half_cnt = '0;
	loop_word_t  i_amp_h = '0;
	loop_word_t  i_amp_l = '0;
	cnt_word_t   i_wait_cnt = '0;
	logic        i_polarity = 1'b0;
	loop_word_t  i_err_offset = '0;
	logic        i_fb_on = 1'b0;
	gain_sel_t   i_gain_step = '0;
	loop_word_t  i_const_step = '0;
	gain_sel_t   i_gain_ramp = '0;
	dac_word_t   o_dac;
	loop_word_t  o_err;
	loop_word_t  o_step;
	logic        o_step_valid;

	// test table from the data file
	int    tv [MAX_TESTS][N_COLS];
	string tv_name [MAX_TESTS];
	int    n_tests = 0;
	int    cycles = 0;
	int    limit = 0;
	integer seed = 32'h46d5;

	// adc source setup of the running test
	logic      cur_follow = 1'b0;
	int        cur_adc_h = 0;
	int        cur_adc_l = 0;
	int        cur_jit = 0;
	dac_word_t cur_dac_h = '0;

	fog_loop_top DUT (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_adc        (i_adc),
		.i_half_cnt   (i_half_cnt),
		.i_amp_h      (i_amp_h),
		.i_amp_l      (i_amp_l),
		.i_wait_cnt   (i_wait_cnt),
		.i_polarity   (i_polarity),
		.i_err_offset (i_err_offset),
		.i_fb_on      (i_fb_on),
		.i_gain_step  (i_gain_step),
		.i_const_step (i_const_step),
		.i_gain_ramp  (i_gain_ramp),
		.o_dac        (o_dac),
		.o_err        (o_err),
		.o_step       (o_step),
		.o_step_valid (o_step_valid)
	);

	// 40 ns period
	always #20 CLOCK_DAC_1 = ~CLOCK_DAC_1;

	// adc model
	// in follow mode the fiber answers the dac level seen on this edge
	always @(posedge CLOCK_DAC_1) begin
		if (cur_follow) begin
			if (o_dac == cur_dac_h) begin
				i_adc <= adc_sample_t'(cur_adc_h);
			end else begin
				i_adc <= adc_sample_t'(cur_adc_l);
			end
		end else if (cur_jit != 0) begin
			// noise in the low bits only
			i_adc <= adc_sample_t'(cur_adc_h + ($random(seed) & cur_jit));
		end else begin
			i_adc <= adc_sample_t'(cur_adc_h);
		end
	end

	// run length guard
	always @(posedge CLOCK_DAC_1) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Errors found");
			$fatal(1);
		end
	end

	task automatic check_value(input string test_name, input string what,
		input int expected, input int actual);
		if (expected != actual) begin
			$display("FAIL %0s %0s: expected %0d actual %0d", test_name, what, expected, actual);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// settings and adc source change under reset
	task automatic apply_settings(input int t);
		@(posedge CLOCK_DAC_1);
		i_rst_n      <= 1'b0;
		i_half_cnt   <= cnt_word_t'(tv[t][C_HALF]);
		i_amp_h      <= loop_word_t'(tv[t][C_AMP_H]);
		i_amp_l      <= loop_word_t'(tv[t][C_AMP_L]);
		i_wait_cnt   <= cnt_word_t'(tv[t][C_WAIT]);
		i_polarity   <= (tv[t][C_POL] != 0);
		i_err_offset <= loop_word_t'(tv[t][C_OFFS]);
		i_fb_on      <= (tv[t][C_FB] != 0);
		i_gain_step  <= gain_sel_t'(tv[t][C_GSTEP]);
		i_const_step <= loop_word_t'(tv[t][C_CONST]);
		i_gain_ramp  <= gain_sel_t'(tv[t][C_GRAMP]);
		cur_follow   <= (tv[t][C_FOLLOW] != 0);
		cur_adc_h    <= tv[t][C_ADC_H];
		cur_adc_l    <= tv[t][C_ADC_L];
		cur_jit      <= tv[t][C_JIT];
		cur_dac_h    <= dac_word_t'(tv[t][C_AMP_H]);
		repeat (2) @(posedge CLOCK_DAC_1);
		i_rst_n <= 1'b1;
	endtask

	task automatic run_test(input int t);
		int        seen;
		int        cyc;
		int        half_len;
		int        ramp_wait;
		int        ramp_inc;
		int        exp_step;
		int        exp_dac;
		logic      mod_chk;
		logic      ramp_chk;
		logic      err_chk;
		dac_word_t dac_h;
		dac_word_t dac_l;
		seen      = 0;
		cyc       = 0;
		ramp_wait = 0;
		exp_step  = 0;
		half_len  = tv[t][C_HALF];
		dac_h     = dac_word_t'(tv[t][C_AMP_H]);
		dac_l     = dac_word_t'(tv[t][C_AMP_L]);
		// ramp sits at zero in open loop with no step
		mod_chk   = (tv[t][C_FB] == 0) && (tv[t][C_CONST] == 0);
		// flat modulation so o_dac shows the bare ramp
		ramp_chk  = (tv[t][C_FB] == 0) && (tv[t][C_CONST] != 0)
			&& (tv[t][C_AMP_H] == tv[t][C_AMP_L]);
		// noisy adc gives an inexact average
		err_chk   = (tv[t][C_JIT] == 0);
		ramp_inc  = tv[t][C_CONST] >>> tv[t][C_GRAMP];
		apply_settings(t);
		while (seen < tv[t][C_UPD] || ramp_wait > 0) begin
			@(negedge CLOCK_DAC_1);
			cyc++;
			if (mod_chk && cyc > 1) begin
				// high half first after reset, o_dac one register behind
				if ((((cyc - 2) / half_len) % 2) == 0) begin
					exp_dac = int'(dac_h);
				end else begin
					exp_dac = int'(dac_l);
				end
				check_value(tv_name[t], "dac level", exp_dac, int'(o_dac));
			end
			if (ramp_wait > 0) begin
				ramp_wait--;
				if (ramp_wait == 0) begin
					// amplitude plus n ramp steps, 16 bit wrap
					exp_dac = (tv[t][C_AMP_H] + seen * ramp_inc) & 32'h0000_ffff;
					check_value(tv_name[t], "ramp dac", exp_dac, int'(o_dac));
				end
			end
			if (o_step_valid) begin
				seen++;
				if (err_chk) begin
					check_value(tv_name[t], "err", tv[t][C_ERR], int'(o_err));
				end
				if (tv[t][C_FB] != 0) begin
					// constant adc leaves only the offset as error
					exp_step = exp_step + (tv[t][C_OFFS] >>> tv[t][C_GSTEP]);
				end else begin
					exp_step = tv[t][C_CONST];
				end
				check_value(tv_name[t], "step", exp_step, int'(o_step));
				// ramp moves one edge later, dac one more
				if (ramp_chk) begin
					ramp_wait = 2;
				end
			end
		end
		check_value(tv_name[t], "final step", tv[t][C_STEP], int'(o_step));
		$display("test %0s: %0d updates checked", tv_name[t], seen);
	endtask

	initial begin
		int    fd;
		int    rc;
		string line;
		fd = $fopen("bench/fog_loop_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test data file bench/fog_loop_testdata.txt");
			$display("Errors found");
			$fatal(1);
		end
		while (!$feof(fd) && n_tests < MAX_TESTS) begin
			rc = $fgets(line, fd);
			// skip comments and blank lines
			if (rc > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
				rc = $sscanf(line,
					"%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
					tv_name[n_tests], tv[n_tests][0], tv[n_tests][1], tv[n_tests][2],
					tv[n_tests][3], tv[n_tests][4], tv[n_tests][5], tv[n_tests][6],
					tv[n_tests][7], tv[n_tests][8], tv[n_tests][9], tv[n_tests][10],
					tv[n_tests][11], tv[n_tests][12], tv[n_tests][13], tv[n_tests][14],
					tv[n_tests][15], tv[n_tests][16]);
				if (rc != N_COLS + 1) begin
					$display("bad line in the test data file: %0s", line);
					$display("Errors found");
					$fatal(1);
				end
				n_tests++;
			end
		end
		$fclose(fd);
		// two warm-up periods per test on top of the updates
		limit = 100;
		for (int t = 0; t < n_tests; t++) begin
			limit += (tv[t][C_UPD] + 2) * 2 * tv[t][C_HALF] + 8;
		end
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("No errors");
		$finish;
	end

endmodule

// File: bench/fog_loop_testdata.txt
# name half_cnt amp_h amp_l wait_cnt polarity err_offset fb_on gain_step const_step gain_ramp
#   adc_h adc_l follow jitter_mask updates exp_err exp_step   (jitter_mask 0 means exact adc)
mod_levels   32  4096 -4096 4 0    0 0 0       0 0  1024  1024 0  7 2     0       0
demod_follow 32  2048 -2048 4 0   25 0 0       0 0  1500  -300 1  0 3  1825       0
demod_neg    32  3000   500 4 0    0 0 0       0 0 -1200  3100 1  0 3 -4300       0
polarity     32  2048 -2048 4 1  -40 0 0       0 0  2000   500 1  0 3 -1540       0
closed_pos   32  1000 -1000 4 0  400 1 2       0 0   777   777 0  0 5   400     500
closed_neg   32  1500 -1500 4 0 -103 1 3       0 0 -2500 -2500 0  0 4  -103     -52
open_loop    32  2048 -2048 4 0   60 0 0   12345 4  1024  1024 0  0 3    60   12345
ramp_up      32   768   768 4 0    0 0 0 1193040 4  2048  2048 0 15 6     0 1193040
ramp_neg     32  -300  -300 4 0    0 0 0  -50000 2  -512  -512 0  3 7     0  -50000

// File: fog_loop.f
+incdir+hdl
hdl/fog_loop_pkg.sv
hdl/fog_mod_gen.sv
hdl/fog_err_demod.sv
hdl/fog_step_gen.sv
hdl/fog_ramp_gen.sv
hdl/fog_loop_top.sv
bench/fog_loop_tb.sv

// File: hdl/fog_err_demod.sv
`include "fog_loop_config.svh"

module fog_err_demod (
	input  logic                      CLOCK_DAC_1,
	input  logic                      i_rst_n,
	input  fog_loop_pkg::adc_sample_t  i_adc,
	input  fog_loop_pkg::mod_half_t    i_mod_half,
	input  logic                      i_mod_switch,
	input  fog_loop_pkg::cnt_word_t    i_wait_cnt,
	input  logic                      i_polarity,
	input  fog_loop_pkg::loop_word_t   i_err_offset,
	output fog_loop_pkg::loop_word_t   o_err,
	output logic                      o_err_valid
);

	import fog_loop_pkg::*;

	// two stage adc capture
	adc_sample_t adc_q1;
	adc_sample_t adc_q2;
	loop_word_t  sample_ext;

	demod_state_t state_q;
	cnt_word_t    wait_q;
	logic [`FOG_AVG_SHIFT-1:0] acc_cnt_q;

	// full set of samples taken in this half
	logic half_ok_q;
	// stored high average came from a full half
	logic have_high_q;

	loop_word_t acc_sum_q;
	loop_word_t high_avg_q;
	loop_word_t avg_now;
	loop_word_t diff;
	loop_word_t err_next;

	assign sample_ext = loop_word_t'(adc_q2);
	assign avg_now    = acc_sum_q >>> `FOG_AVG_SHIFT;

	// high minus low, low average taken straight from the sum
	assign diff     = high_avg_q - avg_now;
	assign err_next = (i_polarity ? -diff : diff) + i_err_offset;

	// datapath, no reset
	always_ff @(posedge CLOCK_DAC_1) begin
		adc_q1 <= i_adc;
		adc_q2 <= adc_q1;
		if (i_mod_switch) begin
			acc_sum_q <= '0;
		end else if (state_q == DEM_ACCUM) begin
			acc_sum_q <= acc_sum_q + sample_ext;
		end
		// new half is low, so the high half just ended
		if (i_mod_switch && i_mod_half == MOD_LOW) begin
			high_avg_q <= avg_now;
		end
	end

	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q     <= DEM_HOLD;
			wait_q      <= '0;
			acc_cnt_q   <= '0;
			half_ok_q   <= 1'b0;
			have_high_q <= 1'b0;
			o_err       <= `FOG_RST_WORD;
			o_err_valid <= 1'b0;
		end else begin
			o_err_valid <= 1'b0;
			if (i_mod_switch) begin
				// restart settle for the new half
				state_q   <= DEM_SETTLE;
				wait_q    <= i_wait_cnt;
				acc_cnt_q <= '0;
				half_ok_q <= 1'b0;
				if (i_mod_half == MOD_LOW) begin
					have_high_q <= half_ok_q;
				end else if (have_high_q && half_ok_q) begin
					// low half just ended, one error per period
					o_err       <= err_next;
					o_err_valid <= 1'b1;
				end
			end else begin
				case (state_q)
					DEM_SETTLE: begin
						if (wait_q <= cnt_word_t'(1)) begin
							state_q <= DEM_ACCUM;
						end else begin
							wait_q <= wait_q - cnt_word_t'(1);
						end
					end
					DEM_ACCUM: begin
						acc_cnt_q <= acc_cnt_q + 1'b1;
						// 16th sample
						if (acc_cnt_q == '1) begin
							state_q   <= DEM_HOLD;
							half_ok_q <= 1'b1;
						end
					end
					default: begin
						state_q <= DEM_HOLD;
					end
				endcase
			end
		end
	end

	// settle plus 16 samples must fit inside a modulation half
	a_accum_fits_half: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		i_mod_switch |-> (state_q == DEM_HOLD)
	);

	// at most one error per period
	a_err_valid_gap: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		o_err_valid |=> !o_err_valid
	);

endmodule

// File: hdl/fog_loop_config.svh
`ifndef FOG_LOOP_CONFIG_SVH
`define FOG_LOOP_CONFIG_SVH

// adc sample width, two's complement
`define FOG_ADC_W 14

// dac code width, straight binary
`define FOG_DAC_W 16

// settings, error, step and ramp words
`define FOG_WORD_W 32

// log2 of samples averaged per half
// 4 gives 16 samples
`define FOG_AVG_SHIFT 4

// gain selector width, shift of 0..31
`define FOG_GAIN_W 5

// reset values
`define FOG_RST_WORD 32'sd0
`define FOG_RST_DAC 16'h0000

`endif

// File: hdl/fog_loop_pkg.sv
`include "fog_loop_config.svh"

package fog_loop_pkg;

	// raw adc sample, signed
	typedef logic signed [`FOG_ADC_W-1:0] adc_sample_t;

	// dac code
	typedef logic [`FOG_DAC_W-1:0] dac_word_t;

	// error, step, ramp, amplitudes, offset
	typedef logic signed [`FOG_WORD_W-1:0] loop_word_t;

	// counters and count settings
	typedef logic [`FOG_WORD_W-1:0] cnt_word_t;

	// arithmetic shift amount
	typedef logic [`FOG_GAIN_W-1:0] gain_sel_t;

	// which half of the square wave is on the modulator
	typedef enum logic {MOD_LOW = 1'b0, MOD_HIGH = 1'b1} mod_half_t;

	// error demodulator sequence within one half
	typedef enum logic [1:0] {DEM_SETTLE = 2'd0, DEM_ACCUM = 2'd1, DEM_HOLD = 2'd2} demod_state_t;

endpackage

// File: hdl/fog_loop_top.sv
module fog_loop_top (
	input  logic                      CLOCK_DAC_1,
	input  logic                      i_rst_n,
	// adc, already in the dac clock domain
	input  fog_loop_pkg::adc_sample_t  i_adc,
	// modulation settings
	input  fog_loop_pkg::cnt_word_t    i_half_cnt,
	input  fog_loop_pkg::loop_word_t   i_amp_h,
	input  fog_loop_pkg::loop_word_t   i_amp_l,
	// demodulator settings
	input  fog_loop_pkg::cnt_word_t    i_wait_cnt,
	input  logic                      i_polarity,
	input  fog_loop_pkg::loop_word_t   i_err_offset,
	// feedback settings
	input  logic                      i_fb_on,
	input  fog_loop_pkg::gain_sel_t    i_gain_step,
	input  fog_loop_pkg::loop_word_t   i_const_step,
	input  fog_loop_pkg::gain_sel_t    i_gain_ramp,
	// modulator drive
	output fog_loop_pkg::dac_word_t    o_dac,
	// readback monitors
	output fog_loop_pkg::loop_word_t   o_err,
	output fog_loop_pkg::loop_word_t   o_step,
	output logic                      o_step_valid
);

	import fog_loop_pkg::*;

	// modulation to demod and ramp
	mod_half_t  mod_half;
	logic       mod_switch;
	loop_word_t mod_level;

	// error to step integrator
	loop_word_t err;
	logic       err_valid;

	// step to ramp
	loop_word_t step;
	logic       step_valid;

	fog_mod_gen u_mod_gen (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_half_cnt   (i_half_cnt),
		.i_amp_h      (i_amp_h),
		.i_amp_l      (i_amp_l),
		.o_mod_half   (mod_half),
		.o_mod_switch (mod_switch),
		.o_mod_level  (mod_level)
	);

	fog_err_demod u_err_demod (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_adc        (i_adc),
		.i_mod_half   (mod_half),
		.i_mod_switch (mod_switch),
		.i_wait_cnt   (i_wait_cnt),
		.i_polarity   (i_polarity),
		.i_err_offset (i_err_offset),
		.o_err        (err),
		.o_err_valid  (err_valid)
	);

	fog_step_gen u_step_gen (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_err        (err),
		.i_err_valid  (err_valid),
		.i_fb_on      (i_fb_on),
		.i_gain_step  (i_gain_step),
		.i_const_step (i_const_step),
		.o_step       (step),
		.o_step_valid (step_valid)
	);

	fog_ramp_gen u_ramp_gen (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst_n      (i_rst_n),
		.i_step       (step),
		.i_step_valid (step_valid),
		.i_gain_ramp  (i_gain_ramp),
		.i_mod_level  (mod_level),
		.o_dac        (o_dac)
	);

	// monitor taps
	assign o_err        = err;
	assign o_step       = step;
	assign o_step_valid = step_valid;

endmodule

// File: hdl/fog_mod_gen.sv
module fog_mod_gen (
	input  logic                    CLOCK_DAC_1,
	input  logic                    i_rst_n,
	input  fog_loop_pkg::cnt_word_t  i_half_cnt,
	input  fog_loop_pkg::loop_word_t i_amp_h,
	input  fog_loop_pkg::loop_word_t i_amp_l,
	output fog_loop_pkg::mod_half_t  o_mod_half,
	output logic                    o_mod_switch,
	output fog_loop_pkg::loop_word_t o_mod_level
);

	import fog_loop_pkg::*;

	// cycles left in the current half
	// zero only right after reset, means not loaded yet
	cnt_word_t cnt_q;
	cnt_word_t cnt_d;
	mod_half_t half_q;
	mod_half_t half_d;
	logic      switch_d;
	loop_word_t level_q;

	always_comb begin
		half_d   = half_q;
		switch_d = 1'b0;
		cnt_d    = cnt_q - cnt_word_t'(1);
		if (cnt_q == '0) begin
			// first cycle after reset already counts as high
			cnt_d = i_half_cnt - cnt_word_t'(1);
		end else if (cnt_q == cnt_word_t'(1)) begin
			// last cycle of this half
			cnt_d    = i_half_cnt;
			half_d   = (half_q == MOD_HIGH) ? MOD_LOW : MOD_HIGH;
			switch_d = 1'b1;
		end
	end

	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_q        <= '0;
			half_q       <= MOD_HIGH;
			o_mod_switch <= 1'b0;
		end else begin
			cnt_q        <= cnt_d;
			half_q       <= half_d;
			o_mod_switch <= switch_d;
		end
	end

	// amplitude follows the next half so it lines up with half_q
	always_ff @(posedge CLOCK_DAC_1) begin
		if (half_d == MOD_HIGH) begin
			level_q <= i_amp_h;
		end else begin
			level_q <= i_amp_l;
		end
	end

	assign o_mod_half  = half_q;
	assign o_mod_level = level_q;

endmodule

// File: hdl/fog_ramp_gen.sv
`include "fog_loop_config.svh"

module fog_ramp_gen (
	input  logic                     CLOCK_DAC_1,
	input  logic                     i_rst_n,
	input  fog_loop_pkg::loop_word_t  i_step,
	input  logic                     i_step_valid,
	input  fog_loop_pkg::gain_sel_t   i_gain_ramp,
	input  fog_loop_pkg::loop_word_t  i_mod_level,
	output fog_loop_pkg::dac_word_t   o_dac
);

	import fog_loop_pkg::*;

	// phase ramp, wraps in 32 bits
	loop_word_t ramp_q;
	loop_word_t step_shift;
	loop_word_t dac_sum;

	assign step_shift = i_step >>> i_gain_ramp;

	// ramp plus square wave
	assign dac_sum = ramp_q + i_mod_level;

	// one ramp step per feedback update
	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ramp_q <= `FOG_RST_WORD;
		end else if (i_step_valid) begin
			ramp_q <= ramp_q + step_shift;
		end
	end

	// dac takes the low bits every cycle
	// upper bits drop, so the phase wraps modulo 2^16
	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_dac <= `FOG_RST_DAC;
		end else begin
			o_dac <= dac_sum[`FOG_DAC_W-1:0];
		end
	end

endmodule

// File: hdl/fog_step_gen.sv
`include "fog_loop_config.svh"

module fog_step_gen (
	input  logic                     CLOCK_DAC_1,
	input  logic                     i_rst_n,
	input  fog_loop_pkg::loop_word_t  i_err,
	input  logic                     i_err_valid,
	input  logic                     i_fb_on,
	input  fog_loop_pkg::gain_sel_t   i_gain_step,
	input  fog_loop_pkg::loop_word_t  i_const_step,
	output fog_loop_pkg::loop_word_t  o_step,
	output logic                     o_step_valid
);

	import fog_loop_pkg::*;

	// loop gain as a right shift, sign kept
	loop_word_t err_shift;
	loop_word_t step_q;

	assign err_shift = i_err >>> i_gain_step;

	always_ff @(posedge CLOCK_DAC_1 or negedge i_rst_n) begin
		if (!i_rst_n) begin
			step_q       <= `FOG_RST_WORD;
			o_step_valid <= 1'b0;
		end else begin
			// one update per valid error
			o_step_valid <= i_err_valid;
			if (i_err_valid) begin
				if (i_fb_on) begin
					// closed loop, integrate
					step_q <= step_q + err_shift;
				end else begin
					// open loop, fixed step
					step_q <= i_const_step;
				end
			end
		end
	end

	assign o_step = step_q;

	// ramp update relies on this fixed one cycle lag
	a_step_follows_err: assert property (
		@(posedge CLOCK_DAC_1) disable iff (!i_rst_n)
		i_err_valid |=> o_step_valid
	);

endmodule
